/* rtl/csr_cfg.svh */
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// data word width
`define CSR_XLEN        32

// free-running time/cycle counter
`define CSR_TIMER_W     64

// U, S and M banks
`define CSR_NUM_LEVELS  3

// delegation register widths
`define CSR_EDELEG_W    16
`define CSR_IDELEG_W    12

`endif

/* rtl/priv_pkg.sv */
`default_nettype none
`include "csr_cfg.svh"

package priv_pkg;

	typedef enum logic [1:0] {
		PRIV_U = 2'b00,
		PRIV_S = 2'b01,
		PRIV_M = 2'b11	// 2'b10 is reserved
	} priv_mode_e;

	typedef struct packed {
		logic                 irq;
		logic [`CSR_XLEN-2:0] code;
	} trap_cause_s;

	// xcause word, seen whole by csr access and split by the trap logic
	typedef union packed {
		logic [`CSR_XLEN-1:0] raw;
		trap_cause_s          f;
	} trap_cause_u;

	// synchronous exception codes
	localparam logic [`CSR_XLEN-2:0] EXC_I_ADDR_MISALIGNED = 'd0;
	localparam logic [`CSR_XLEN-2:0] EXC_I_ACCESS_FAULT    = 'd1;
	localparam logic [`CSR_XLEN-2:0] EXC_I_ILLEGAL         = 'd2;
	localparam logic [`CSR_XLEN-2:0] EXC_BREAKPOINT        = 'd3;
	localparam logic [`CSR_XLEN-2:0] EXC_L_ADDR_MISALIGNED = 'd4;
	localparam logic [`CSR_XLEN-2:0] EXC_S_ADDR_MISALIGNED = 'd6;
	localparam logic [`CSR_XLEN-2:0] EXC_U_CALL            = 'd8;
	localparam logic [`CSR_XLEN-2:0] EXC_S_CALL            = 'd9;
	localparam logic [`CSR_XLEN-2:0] EXC_M_CALL            = 'd11;

	// interrupt codes, used with irq set
	localparam logic [`CSR_XLEN-2:0] INT_S_TIMER           = 'd5;
	localparam logic [`CSR_XLEN-2:0] INT_M_TIMER           = 'd7;

	// bank index to level number; the last bank is machine mode
	function automatic int bank_level(input int idx);
		return (idx == `CSR_NUM_LEVELS - 1) ? int'(PRIV_M) : idx;
	endfunction

endpackage

`default_nettype wire

/* rtl/csr_map_pkg.sv */
`default_nettype none

package csr_map_pkg;

	typedef logic [11:0] csr_addr_t;

	// per-level tables, indexed by mode value
	// entry 2 belongs to the reserved mode and is never decoded
	localparam csr_addr_t STATUS_ADDR [4] = '{
		12'h000, 12'h100, 12'hfff, 12'h300
	};
	localparam csr_addr_t TVEC_ADDR [4] = '{
		12'h005, 12'h105, 12'hfff, 12'h305
	};
	localparam csr_addr_t SCRATCH_ADDR [4] = '{
		12'h040, 12'h140, 12'hfff, 12'h340
	};
	localparam csr_addr_t EPC_ADDR [4] = '{
		12'h041, 12'h141, 12'hfff, 12'h341
	};
	localparam csr_addr_t CAUSE_ADDR [4] = '{
		12'h042, 12'h142, 12'hfff, 12'h342
	};
	localparam csr_addr_t TVAL_ADDR [4] = '{
		12'h043, 12'h143, 12'hfff, 12'h343
	};
	localparam csr_addr_t TIMECMP_ADDR [4] = '{
		12'h8ff, 12'h5c0, 12'hfff, 12'hbbf	// custom compare slots
	};

	// delegation
	localparam csr_addr_t CSR_MEDELEG = 12'h302;
	localparam csr_addr_t CSR_MIDELEG = 12'h303;
	localparam csr_addr_t CSR_SEDELEG = 12'h102;
	localparam csr_addr_t CSR_SIDELEG = 12'h103;

	// counters, time and cycle share one source
	localparam csr_addr_t CSR_CYCLE   = 12'hc00;
	localparam csr_addr_t CSR_TIME    = 12'hc01;
	localparam csr_addr_t CSR_CYCLEH  = 12'hc80;
	localparam csr_addr_t CSR_TIMEH   = 12'hc81;

endpackage

`default_nettype wire

/* rtl/priv_router.sv */
`timescale 1ns/1ps
`default_nettype none
`include "csr_cfg.svh"

module priv_router (
	input  logic                              clk,
	input  logic                              nrst,
	input  logic                              csr_we,
	input  csr_map_pkg::csr_addr_t            csr_address_wb,
	input  logic [`CSR_XLEN-1:0]              csr_wb,
	input  logic                              exception_pending,
	input  priv_pkg::trap_cause_u             cause,
	input  logic                              m_ret,
	input  logic                              s_ret,
	input  logic                              u_ret,
	input  csr_map_pkg::csr_addr_t            csr_address_r,
	output priv_pkg::priv_mode_e              current_mode,
	output logic [`CSR_NUM_LEVELS-1:0]        take_trap,
	output logic [`CSR_NUM_LEVELS-1:0]        take_ret,
	output logic [`CSR_TIMER_W-1:0]           timer,
	output priv_pkg::priv_mode_e              mpp,
	output logic                              spp,
	output logic [`CSR_NUM_LEVELS-1:0]        redirect_sel,
	output logic                              redirect_ret,
	output logic                              rd_hit,
	output logic [`CSR_XLEN-1:0]              rd_data
);
	import priv_pkg::*;
	import csr_map_pkg::*;

	localparam int DIDX_W = $clog2(`CSR_EDELEG_W);

	logic [`CSR_EDELEG_W-1:0] medeleg;
	logic [`CSR_EDELEG_W-1:0] sedeleg;
	logic [`CSR_IDELEG_W-1:0] mideleg;
	logic [`CSR_IDELEG_W-1:0] sideleg;
	logic [`CSR_EDELEG_W-1:0] mideleg_x;
	logic [`CSR_EDELEG_W-1:0] sideleg_x;
	logic [DIDX_W-1:0]        deleg_idx;
	logic                     m_bit;
	logic                     s_bit;
	logic                     is_ret;
	priv_mode_e               trap_mode;
	priv_mode_e               next_mode;

	// one-hot bank select for a mode
	function automatic logic [`CSR_NUM_LEVELS-1:0] level_sel(input priv_mode_e m);
		logic [`CSR_NUM_LEVELS-1:0] sel;
		for (int i = 0; i < `CSR_NUM_LEVELS; i++)
			sel[i] = (m == priv_mode_e'(bank_level(i)));
		return sel;
	endfunction

	assign mideleg_x = {{(`CSR_EDELEG_W-`CSR_IDELEG_W){1'b0}}, mideleg};
	assign sideleg_x = {{(`CSR_EDELEG_W-`CSR_IDELEG_W){1'b0}}, sideleg};
	assign deleg_idx = cause.f.code[DIDX_W-1:0];
	assign m_bit     = cause.f.irq ? mideleg_x[deleg_idx] : medeleg[deleg_idx];
	assign s_bit     = cause.f.irq ? sideleg_x[deleg_idx] : sedeleg[deleg_idx];
	assign is_ret    = m_ret | s_ret | u_ret;

	always_comb
	begin
		if (m_bit && s_bit)
			trap_mode = PRIV_U;
		else if (m_bit)
			trap_mode = PRIV_S;
		else
			trap_mode = PRIV_M;

		next_mode = current_mode;
		if (exception_pending)
		begin
			if (m_ret)
				next_mode = mpp;
			else if (s_ret)
				next_mode = spp ? PRIV_S : PRIV_U;
			else if (u_ret)
				next_mode = PRIV_U;
			else
				next_mode = trap_mode;
		end
	end

	assign take_trap    = (exception_pending && !is_ret) ? level_sel(trap_mode) : '0;
	assign take_ret     = exception_pending ? {m_ret, s_ret, u_ret} : '0;
	assign redirect_ret = is_ret;
	assign redirect_sel = is_ret ? {m_ret, s_ret, u_ret} : level_sel(next_mode);

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			current_mode <= PRIV_M;	// hart leaves reset in M
			mpp          <= PRIV_M;
			spp          <= 1'b0;
			medeleg      <= '0;
			mideleg      <= '0;
			sedeleg      <= '0;
			sideleg      <= '0;
		end
		else
		begin
			current_mode <= next_mode;
			if (exception_pending)
			begin
				if (take_trap[`CSR_NUM_LEVELS-1])
					mpp <= current_mode;
				if (take_trap[1])
					spp <= (current_mode != PRIV_U);
				if (m_ret)
					mpp <= PRIV_U;	// stack pops to U
				if (s_ret)
					spp <= 1'b0;
			end
			else if (csr_we)
			begin
				case (csr_address_wb)
					CSR_MEDELEG: medeleg <= csr_wb[`CSR_EDELEG_W-1:0];
					CSR_MIDELEG: mideleg <= csr_wb[`CSR_IDELEG_W-1:0];
					CSR_SEDELEG: sedeleg <= csr_wb[`CSR_EDELEG_W-1:0];
					CSR_SIDELEG: sideleg <= csr_wb[`CSR_IDELEG_W-1:0];
					STATUS_ADDR[PRIV_M]:
					begin
						// reserved encoding keeps the old mpp
						if (csr_wb[12:11] != 2'b10)
							mpp <= priv_mode_e'(csr_wb[12:11]);
						spp <= csr_wb[8];
					end
					STATUS_ADDR[PRIV_S]: spp <= csr_wb[8];
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			timer <= '0;
		else
			timer <= timer + 1'b1;
	end

	always_comb
	begin
		rd_hit  = 1'b1;
		rd_data = '0;
		case (csr_address_r)
			CSR_MEDELEG: rd_data = {{(`CSR_XLEN-`CSR_EDELEG_W){1'b0}}, medeleg};
			CSR_MIDELEG: rd_data = {{(`CSR_XLEN-`CSR_IDELEG_W){1'b0}}, mideleg};
			CSR_SEDELEG: rd_data = {{(`CSR_XLEN-`CSR_EDELEG_W){1'b0}}, sedeleg};
			CSR_SIDELEG: rd_data = {{(`CSR_XLEN-`CSR_IDELEG_W){1'b0}}, sideleg};
			CSR_TIME, CSR_CYCLE:   rd_data = timer[`CSR_XLEN-1:0];
			CSR_TIMEH, CSR_CYCLEH: rd_data = timer[`CSR_TIMER_W-1:`CSR_XLEN];
			default: rd_hit = 1'b0;
		endcase
	end

	// the core issues one xret at a time
	a_one_xret: assert property (@(posedge clk) disable iff (!nrst)
		exception_pending |-> $onehot0({m_ret, s_ret, u_ret}));

endmodule

`default_nettype wire

/* rtl/priv_level_bank.sv */
`timescale 1ns/1ps
`default_nettype none
`include "csr_cfg.svh"

module priv_level_bank #(
	parameter int LEVEL = 3	// mode value of this bank
) (
	input  logic                          clk,
	input  logic                          nrst,
	input  logic                          csr_we,
	input  csr_map_pkg::csr_addr_t        csr_address_wb,
	input  logic [`CSR_XLEN-1:0]          csr_wb,
	input  csr_map_pkg::csr_addr_t        csr_address_r,
	input  logic                          take_trap,
	input  logic                          take_ret,
	input  priv_pkg::trap_cause_u         cause,
	input  logic [`CSR_XLEN-1:0]          pc_exc,
	input  logic [`CSR_TIMER_W-1:0]       timer,
	output logic                          ie,
	output logic                          pie,
	output logic [`CSR_XLEN-1:0]          tvec,
	output logic [`CSR_XLEN-1:0]          epc_val,
	output logic                          timer_irq,
	output logic                          rd_hit,
	output logic [`CSR_XLEN-1:0]          rd_data
);
	import priv_pkg::*;
	import csr_map_pkg::*;

	logic [`CSR_XLEN-1:2] tvec_q;	// direct mode only
	logic [`CSR_XLEN-1:0] scratch;
	logic [`CSR_XLEN-1:2] epc_q;
	trap_cause_u          xcause;
	logic [`CSR_XLEN-1:0] tval;
	logic [`CSR_XLEN-1:0] timecmp;
	logic                 status_wr;
	logic [`CSR_XLEN-1:0] trap_tval;

	assign tvec    = {tvec_q, 2'b00};
	assign epc_val = {epc_q, 2'b00};

	// own status view plus the views of every higher level
	assign status_wr = (csr_address_wb == STATUS_ADDR[LEVEL])
		|| (LEVEL < 1 && csr_address_wb == STATUS_ADDR[1])
		|| (LEVEL < 3 && csr_address_wb == STATUS_ADDR[3]);

	always_comb
	begin
		trap_tval = '0;
		// only a misaligned fetch reports the faulting address
		if (!cause.f.irq && cause.f.code == EXC_I_ADDR_MISALIGNED)
			trap_tval = {pc_exc[`CSR_XLEN-1:1], 1'b0};
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			ie         <= 1'b0;
			pie        <= 1'b0;
			tvec_q     <= '0;
			scratch    <= '0;
			epc_q      <= '0;
			xcause.raw <= '0;
			tval       <= '0;
			timecmp    <= '0;
		end
		else if (take_trap)
		begin
			epc_q  <= pc_exc[`CSR_XLEN-1:2];
			xcause <= cause;
			tval   <= trap_tval;
			pie    <= ie;
			ie     <= 1'b0;	// interrupts off on entry
		end
		else if (take_ret)
		begin
			ie  <= pie;
			pie <= 1'b1;
		end
		else if (csr_we)
		begin
			if (status_wr)
			begin
				ie  <= csr_wb[LEVEL];
				pie <= csr_wb[4+LEVEL];
			end
			case (csr_address_wb)
				TVEC_ADDR[LEVEL]:    tvec_q     <= csr_wb[`CSR_XLEN-1:2];
				SCRATCH_ADDR[LEVEL]: scratch    <= csr_wb;
				EPC_ADDR[LEVEL]:     epc_q      <= csr_wb[`CSR_XLEN-1:2];
				CAUSE_ADDR[LEVEL]:   xcause.raw <= csr_wb;
				TVAL_ADDR[LEVEL]:    tval       <= csr_wb;
				TIMECMP_ADDR[LEVEL]: timecmp    <= csr_wb;
				default: ;
			endcase
		end
	end

	// compare against the full counter, upper half of timecmp is zero
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			timer_irq <= 1'b0;
		else
			timer_irq <= (timer >= {{(`CSR_TIMER_W-`CSR_XLEN){1'b0}}, timecmp});
	end

	always_comb
	begin
		rd_hit  = 1'b1;
		rd_data = '0;
		case (csr_address_r)
			TVEC_ADDR[LEVEL]:    rd_data = tvec;
			SCRATCH_ADDR[LEVEL]: rd_data = scratch;
			EPC_ADDR[LEVEL]:     rd_data = epc_val;
			CAUSE_ADDR[LEVEL]:   rd_data = xcause.raw;
			TVAL_ADDR[LEVEL]:    rd_data = tval;
			TIMECMP_ADDR[LEVEL]: rd_data = timecmp;
			default: rd_hit = 1'b0;
		endcase
	end

	// router never enters and leaves the same level at once
	a_trap_xor_ret: assert property (@(posedge clk) disable iff (!nrst)
		!(take_trap && take_ret));

endmodule

`default_nettype wire

/* rtl/csr_read_path.sv */
`timescale 1ns/1ps
`default_nettype none
`include "csr_cfg.svh"

module csr_read_path (
	input  csr_map_pkg::csr_addr_t       csr_address_r,
	input  logic                         router_hit,
	input  logic [`CSR_XLEN-1:0]         router_data,
	input  priv_pkg::priv_mode_e         mpp,
	input  logic                         spp,
	input  logic [`CSR_NUM_LEVELS-1:0]   redirect_sel,
	input  logic                         redirect_ret,
	input  logic [`CSR_NUM_LEVELS-1:0]   ie,
	input  logic [`CSR_NUM_LEVELS-1:0]   pie,
	input  logic [`CSR_XLEN-1:0]         tvec [`CSR_NUM_LEVELS],
	input  logic [`CSR_XLEN-1:0]         epc_val [`CSR_NUM_LEVELS],
	input  logic [`CSR_NUM_LEVELS-1:0]   bank_hit,
	input  logic [`CSR_XLEN-1:0]         bank_data [`CSR_NUM_LEVELS],
	output logic [`CSR_XLEN-1:0]         csr_data,
	output logic [`CSR_XLEN-1:0]         epc
);
	import priv_pkg::*;
	import csr_map_pkg::*;

	localparam logic [`CSR_XLEN-1:0] SSTATUS_MASK = 'h133;	// uie sie upie spie spp
	localparam logic [`CSR_XLEN-1:0] USTATUS_MASK = 'h011;	// uie upie

	logic [`CSR_XLEN-1:0] mstatus;

	always_comb
	begin
		mstatus = '0;
		for (int i = 0; i < `CSR_NUM_LEVELS; i++)
		begin
			mstatus[bank_level(i)]     = ie[i];
			mstatus[4 + bank_level(i)] = pie[i];
		end
		mstatus[8]     = spp;
		mstatus[12:11] = mpp;
	end

	// sources decode disjoint addresses, so order does not matter
	always_comb
	begin
		csr_data = '0;
		if (router_hit)
			csr_data = router_data;
		for (int i = 0; i < `CSR_NUM_LEVELS; i++)
			if (bank_hit[i])
				csr_data = bank_data[i];
		case (csr_address_r)
			STATUS_ADDR[PRIV_M]: csr_data = mstatus;
			STATUS_ADDR[PRIV_S]: csr_data = mstatus & SSTATUS_MASK;
			STATUS_ADDR[PRIV_U]: csr_data = mstatus & USTATUS_MASK;
			default: ;
		endcase
	end

	// redirect to the front end
	always_comb
	begin
		epc = '0;
		for (int i = 0; i < `CSR_NUM_LEVELS; i++)
			if (redirect_sel[i])
				epc = redirect_ret ? epc_val[i] : tvec[i];
	end

endmodule

`default_nettype wire

/* rtl/csr_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "csr_cfg.svh"

module csr_top (
	input  logic                     clk,
	input  logic                     nrst,
	input  logic                     csr_we,
	input  csr_map_pkg::csr_addr_t   csr_address_wb,
	input  logic [`CSR_XLEN-1:0]     csr_wb,
	input  csr_map_pkg::csr_addr_t   csr_address_r,
	input  logic                     exception_pending,
	input  priv_pkg::trap_cause_u    cause,
	input  logic [`CSR_XLEN-1:0]     pc_exc,
	input  logic                     m_ret,
	input  logic                     s_ret,
	input  logic                     u_ret,
	output logic [`CSR_XLEN-1:0]     csr_data,
	output priv_pkg::priv_mode_e     current_mode,
	output logic [`CSR_XLEN-1:0]     epc,
	output logic                     m_timer,
	output logic                     s_timer,
	output logic                     u_timer
);
	import priv_pkg::*;

	logic [`CSR_NUM_LEVELS-1:0] take_trap;
	logic [`CSR_NUM_LEVELS-1:0] take_ret;
	logic [`CSR_TIMER_W-1:0]    timer;
	priv_mode_e                 mpp;
	logic                       spp;
	logic [`CSR_NUM_LEVELS-1:0] redirect_sel;
	logic                       redirect_ret;
	logic                       router_hit;
	logic [`CSR_XLEN-1:0]       router_data;
	logic [`CSR_NUM_LEVELS-1:0] bank_ie;
	logic [`CSR_NUM_LEVELS-1:0] bank_pie;
	logic [`CSR_XLEN-1:0]       bank_tvec [`CSR_NUM_LEVELS];
	logic [`CSR_XLEN-1:0]       bank_epc [`CSR_NUM_LEVELS];
	logic [`CSR_NUM_LEVELS-1:0] timer_irq;
	logic [`CSR_NUM_LEVELS-1:0] bank_hit;
	logic [`CSR_XLEN-1:0]       bank_data [`CSR_NUM_LEVELS];

	priv_router u_router (
		.clk               (clk),
		.nrst              (nrst),
		.csr_we            (csr_we),
		.csr_address_wb    (csr_address_wb),
		.csr_wb            (csr_wb),
		.exception_pending (exception_pending),
		.cause             (cause),
		.m_ret             (m_ret),
		.s_ret             (s_ret),
		.u_ret             (u_ret),
		.csr_address_r     (csr_address_r),
		.current_mode      (current_mode),
		.take_trap         (take_trap),
		.take_ret          (take_ret),
		.timer             (timer),
		.mpp               (mpp),
		.spp               (spp),
		.redirect_sel      (redirect_sel),
		.redirect_ret      (redirect_ret),
		.rd_hit            (router_hit),
		.rd_data           (router_data)
	);

	genvar i;
	generate
		for (i = 0; i < `CSR_NUM_LEVELS; i++)
		begin : g_bank
			priv_level_bank #(
				.LEVEL (bank_level(i))
			) u_bank (
				.clk            (clk),
				.nrst           (nrst),
				.csr_we         (csr_we && !exception_pending),	// trap wins
				.csr_address_wb (csr_address_wb),
				.csr_wb         (csr_wb),
				.csr_address_r  (csr_address_r),
				.take_trap      (take_trap[i]),
				.take_ret       (take_ret[i]),
				.cause          (cause),
				.pc_exc         (pc_exc),
				.timer          (timer),
				.ie             (bank_ie[i]),
				.pie            (bank_pie[i]),
				.tvec           (bank_tvec[i]),
				.epc_val        (bank_epc[i]),
				.timer_irq      (timer_irq[i]),
				.rd_hit         (bank_hit[i]),
				.rd_data        (bank_data[i])
			);
		end
	endgenerate

	csr_read_path u_read_path (
		.csr_address_r (csr_address_r),
		.router_hit    (router_hit),
		.router_data   (router_data),
		.mpp           (mpp),
		.spp           (spp),
		.redirect_sel  (redirect_sel),
		.redirect_ret  (redirect_ret),
		.ie            (bank_ie),
		.pie           (bank_pie),
		.tvec          (bank_tvec),
		.epc_val       (bank_epc),
		.bank_hit      (bank_hit),
		.bank_data     (bank_data),
		.csr_data      (csr_data),
		.epc           (epc)
	);

	// bank order is U, S, M
	assign u_timer = timer_irq[0];
	assign s_timer = timer_irq[1];
	assign m_timer = timer_irq[`CSR_NUM_LEVELS-1];

endmodule

`default_nettype wire

/* sim/tb_csr_tasks.svh */
`ifndef TB_CSR_TASKS_SVH
`define TB_CSR_TASKS_SVH

task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
	assert (got === exp)
	else
	begin
		$display("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
		err_count++;
	end
endtask

task automatic report_failure(input string what);
	$display("Failure at %0d ns: %s", $time, what);
	err_count++;
endtask

task automatic start_test();
	test_errs = err_count;
endtask

task automatic finish_test(input string name);
	test_count++;
	if (err_count == test_errs)
		$display("%s: passed", name);
	else
	begin
		failed_tests++;
		$display("%s: failed with %0d errors", name, err_count - test_errs);
	end
endtask

task automatic abort_on_timeout(input string what);
	$display("Timeout: no %s within %0d cycles", what, MAX_WAIT);
	$display("Test FAILED");
	$finish;
endtask

task automatic write_csr(input csr_addr_t addr, input logic [`CSR_XLEN-1:0] data);
	@(posedge clk);
	csr_we         <= 1'b1;
	csr_address_wb <= addr;
	csr_wb         <= data;
	@(posedge clk);
	csr_we <= 1'b0;
endtask

// csr_data is combinational, sampled mid-cycle
task automatic read_csr(input csr_addr_t addr, output logic [`CSR_XLEN-1:0] data);
	@(posedge clk);
	csr_address_r <= addr;
	@(negedge clk);
	data = csr_data;
endtask

// one-cycle trap or xret strobe, returns the redirect seen in that cycle
task automatic pulse_trap(input logic [`CSR_XLEN-1:0] cw, input logic [`CSR_XLEN-1:0] pc,
	input logic [2:0] rets, output logic [`CSR_XLEN-1:0] redirect);
	trap_cause_u c;
	c.raw = cw;
	@(posedge clk);
	exception_pending <= 1'b1;
	cause             <= c;
	pc_exc            <= pc;
	m_ret             <= rets[2];
	s_ret             <= rets[1];
	u_ret             <= rets[0];
	@(negedge clk);
	redirect = epc;
	@(posedge clk);
	exception_pending <= 1'b0;
	m_ret             <= 1'b0;
	s_ret             <= 1'b0;
	u_ret             <= 1'b0;
endtask

// target level from the delegation values written so far
function automatic int expected_target(input logic [`CSR_XLEN-1:0] cw);
	logic m_bit;
	logic s_bit;
	m_bit = cw[31] ? mideleg_copy[cw[3:0]] : medeleg_copy[cw[3:0]];
	s_bit = cw[31] ? sideleg_copy[cw[3:0]] : sedeleg_copy[cw[3:0]];
	if (m_bit && s_bit)
		return 0;
	if (m_bit)
		return 1;
	return 3;
endfunction

task automatic trap_and_check(input logic [`CSR_XLEN-1:0] cw, input int lvl);
	logic [`CSR_XLEN-1:0] pc;
	logic [`CSR_XLEN-1:0] red;
	logic [`CSR_XLEN-1:0] d;
	logic [`CSR_XLEN-1:0] tval_exp;
	pc       = $urandom();
	tval_exp = (!cw[31] && cw[30:0] == 0) ? (pc & ~32'h1) : '0;	// misaligned fetch only
	pulse_trap(cw, pc, 3'b000, red);
	check_value("epc", red, exp_tvec[lvl]);
	read_csr(EPC_ADDR[lvl], d);
	check_value("current_mode", current_mode, lvl);
	check_value($sformatf("csr %03h", EPC_ADDR[lvl]), d, pc & ~32'h3);
	exp_epc[lvl] = pc & ~32'h3;
	read_csr(CAUSE_ADDR[lvl], d);
	check_value($sformatf("csr %03h", CAUSE_ADDR[lvl]), d, cw);
	read_csr(TVAL_ADDR[lvl], d);
	check_value($sformatf("csr %03h", TVAL_ADDR[lvl]), d, tval_exp);
endtask

task automatic wait_m_timer(input logic level);
	int n;
	n = 0;
	while (m_timer !== level && n < MAX_WAIT)
	begin
		@(negedge clk);
		check_value("s_timer", s_timer, 1'b1);	// stimecmp stays 0
		check_value("u_timer", u_timer, 1'b0);	// utimecmp out of reach
		n++;
	end
	if (m_timer !== level)
		abort_on_timeout(level ? "rising m_timer" : "falling m_timer");
endtask

task automatic test_reset();
	logic [`CSR_XLEN-1:0] d;
	start_test();
	read_csr(STATUS_ADDR[3], d);
	check_value("current_mode", current_mode, 2'b11);
	check_value("mstatus", d, 32'h0000_1800);
	read_csr(SCRATCH_ADDR[3], d);
	check_value("mscratch", d, 0);
	finish_test("reset");
endtask

task automatic test_scratch_rw();
	int                   lv [3] = '{0, 1, 3};
	logic [`CSR_XLEN-1:0] r;
	logic [`CSR_XLEN-1:0] d;
	logic [`CSR_XLEN-1:0] old;
	trap_cause_u          c;
	start_test();
	foreach (lv[k])
	begin
		r = $urandom();
		write_csr(SCRATCH_ADDR[lv[k]], r);
		read_csr(SCRATCH_ADDR[lv[k]], d);
		check_value($sformatf("csr %03h", SCRATCH_ADDR[lv[k]]), d, r);
		r = $urandom();
		exp_tvec[lv[k]] = r & ~32'h3;
		write_csr(TVEC_ADDR[lv[k]], r);
		read_csr(TVEC_ADDR[lv[k]], d);
		check_value($sformatf("csr %03h", TVEC_ADDR[lv[k]]), d, exp_tvec[lv[k]]);
		r = $urandom();
		exp_epc[lv[k]] = r & ~32'h3;
		write_csr(EPC_ADDR[lv[k]], r);
		read_csr(EPC_ADDR[lv[k]], d);
		check_value($sformatf("csr %03h", EPC_ADDR[lv[k]]), d, exp_epc[lv[k]]);
	end
	// write and trap in the same cycle, the trap wins
	old = $urandom();
	write_csr(SCRATCH_ADDR[3], old);
	c.raw = {1'b0, EXC_BREAKPOINT};
	@(posedge clk);
	csr_we            <= 1'b1;
	csr_address_wb    <= SCRATCH_ADDR[3];
	csr_wb            <= ~old;
	exception_pending <= 1'b1;
	cause             <= c;
	pc_exc            <= $urandom();
	@(posedge clk);
	csr_we            <= 1'b0;
	exception_pending <= 1'b0;
	read_csr(SCRATCH_ADDR[3], d);
	check_value("mscratch", d, old);
	finish_test("scratch, tvec and epc access");
endtask

task automatic test_trap_m();
	logic [`CSR_XLEN-1:0] red;
	logic [`CSR_XLEN-1:0] st;
	start_test();
	write_csr(STATUS_ADDR[3], 32'h0000_0800);	// mpp = S
	pulse_trap('0, '0, 3'b100, red);
	write_csr(STATUS_ADDR[3], 32'h0000_0008);	// mie set, mpp = U
	read_csr(STATUS_ADDR[3], st);
	check_value("current_mode", current_mode, 2'b01);	// mret went to S
	check_value("mstatus", st, 32'h0000_0008);
	trap_and_check({1'b0, EXC_I_ADDR_MISALIGNED}, expected_target({1'b0, EXC_I_ADDR_MISALIGNED}));
	read_csr(STATUS_ADDR[3], st);
	check_value("mstatus.mpie", st[7], 1'b1);	// mie before the trap
	check_value("mstatus.mie", st[3], 1'b0);
	check_value("mstatus.mpp", st[12:11], 2'b01);	// trapped from S
	trap_and_check({1'b0, EXC_I_ILLEGAL}, 3);	// tval cleared
	finish_test("machine trap");
endtask

task automatic test_delegation();
	logic [`CSR_XLEN-1:0] d;
	start_test();
	medeleg_copy = 32'h1 << 3;
	write_csr(CSR_MEDELEG, medeleg_copy);
	read_csr(CSR_MEDELEG, d);
	check_value("medeleg", d, medeleg_copy);
	trap_and_check({1'b0, EXC_BREAKPOINT}, expected_target({1'b0, EXC_BREAKPOINT}));
	trap_and_check({1'b0, EXC_I_ILLEGAL}, expected_target({1'b0, EXC_I_ILLEGAL}));
	sedeleg_copy = 32'h1 << 3;
	write_csr(CSR_SEDELEG, sedeleg_copy);
	trap_and_check({1'b0, EXC_BREAKPOINT}, expected_target({1'b0, EXC_BREAKPOINT}));
	mideleg_copy = 32'h1 << 5;
	write_csr(CSR_MIDELEG, mideleg_copy);
	trap_and_check({1'b1, INT_S_TIMER}, expected_target({1'b1, INT_S_TIMER}));
	sideleg_copy = 32'h1 << 5;
	write_csr(CSR_SIDELEG, sideleg_copy);
	trap_and_check({1'b1, INT_S_TIMER}, expected_target({1'b1, INT_S_TIMER}));
	medeleg_copy = '0;
	mideleg_copy = '0;
	sedeleg_copy = '0;
	sideleg_copy = '0;
	write_csr(CSR_MEDELEG, '0);
	write_csr(CSR_MIDELEG, '0);
	write_csr(CSR_SEDELEG, '0);
	write_csr(CSR_SIDELEG, '0);
	finish_test("delegation");
endtask

task automatic test_returns();
	logic [`CSR_XLEN-1:0] red;
	logic [`CSR_XLEN-1:0] st;
	start_test();
	write_csr(STATUS_ADDR[3], 32'h0000_0980);	// mpp = S, spp and mpie set
	read_csr(STATUS_ADDR[3], st);
	check_value("mstatus", st, 32'h0000_0980);
	pulse_trap('0, '0, 3'b100, red);
	check_value("epc", red, exp_epc[3]);
	read_csr(STATUS_ADDR[3], st);
	check_value("current_mode", current_mode, 2'b01);	// mpp was S
	check_value("mstatus.mie", st[3], 1'b1);	// from mpie
	check_value("mstatus.mpie", st[7], 1'b1);
	check_value("mstatus.mpp", st[12:11], 2'b00);
	pulse_trap('0, '0, 3'b001, red);	// leaves S for U
	check_value("epc", red, exp_epc[0]);
	@(negedge clk);
	check_value("current_mode", current_mode, 2'b00);
	pulse_trap('0, '0, 3'b010, red);
	check_value("epc", red, exp_epc[1]);
	@(negedge clk);
	check_value("current_mode", current_mode, 2'b01);	// spp still set
	pulse_trap('0, '0, 3'b010, red);	// spp now clear
	@(negedge clk);
	check_value("current_mode", current_mode, 2'b00);
	finish_test("xret");
endtask

task automatic test_timer();
	logic [`CSR_XLEN-1:0] t0;
	logic [`CSR_XLEN-1:0] t1;
	logic [`CSR_XLEN-1:0] cmp;
	start_test();
	read_csr(CSR_TIME, t0);
	read_csr(CSR_TIME, t1);
	assert (t1 > t0)
	else
		report_failure("time did not advance between two reads");
	write_csr(TIMECMP_ADDR[0], 32'hffff_ffff);
	cmp = t1 + 20;
	write_csr(TIMECMP_ADDR[3], cmp);
	wait_m_timer(1'b0);
	wait_m_timer(1'b1);
	read_csr(CSR_TIME, t1);
	assert (t1 >= cmp)
	else
		report_failure("m_timer rose before time reached mtimecmp");
	finish_test("timer");
endtask

`endif

/* sim/tb_csr_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "csr_cfg.svh"

module tb_csr_top;
	import priv_pkg::*;
	import csr_map_pkg::*;

	localparam int MAX_WAIT = 200;	// cycles per wait loop

	logic                       clk;
	logic                       nrst;
	logic                       csr_we;
	csr_addr_t                  csr_address_wb;
	logic [`CSR_XLEN-1:0]       csr_wb;
	csr_addr_t                  csr_address_r;
	logic                       exception_pending;
	trap_cause_u                cause;
	logic [`CSR_XLEN-1:0]       pc_exc;
	logic                       m_ret;
	logic                       s_ret;
	logic                       u_ret;
	logic [`CSR_XLEN-1:0]       csr_data;
	priv_mode_e                 current_mode;
	logic [`CSR_XLEN-1:0]       epc;
	logic                       m_timer;
	logic                       s_timer;
	logic                       u_timer;

	int                         err_count;
	int                         test_count;
	int                         failed_tests;
	int                         test_errs;	// error count when the test started
	logic [`CSR_XLEN-1:0]       exp_tvec [4];	// indexed by mode value
	logic [`CSR_XLEN-1:0]       exp_epc [4];
	logic [`CSR_XLEN-1:0]       medeleg_copy;
	logic [`CSR_XLEN-1:0]       mideleg_copy;
	logic [`CSR_XLEN-1:0]       sedeleg_copy;
	logic [`CSR_XLEN-1:0]       sideleg_copy;

	csr_top i_dut (
		.clk               (clk),
		.nrst              (nrst),
		.csr_we            (csr_we),
		.csr_address_wb    (csr_address_wb),
		.csr_wb            (csr_wb),
		.csr_address_r     (csr_address_r),
		.exception_pending (exception_pending),
		.cause             (cause),
		.pc_exc            (pc_exc),
		.m_ret             (m_ret),
		.s_ret             (s_ret),
		.u_ret             (u_ret),
		.csr_data          (csr_data),
		.current_mode      (current_mode),
		.epc               (epc),
		.m_timer           (m_timer),
		.s_timer           (s_timer),
		.u_timer           (u_timer)
	);

	`include "tb_csr_tasks.svh"

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;	// 100 ns period
	end

	initial
	begin
		void'($urandom(21));
		nrst              = 1'b0;
		csr_we            = 1'b0;
		csr_address_wb    = '0;
		csr_wb            = '0;
		csr_address_r     = '0;
		exception_pending = 1'b0;
		cause             = '0;
		pc_exc            = '0;
		m_ret             = 1'b0;
		s_ret             = 1'b0;
		u_ret             = 1'b0;
		err_count         = 0;
		test_count        = 0;
		failed_tests      = 0;
		test_errs         = 0;
		medeleg_copy      = '0;
		mideleg_copy      = '0;
		sedeleg_copy      = '0;
		sideleg_copy      = '0;
		repeat (10) @(posedge clk);
		nrst <= 1'b1;
		@(posedge clk);

		test_reset();
		test_scratch_rw();
		test_trap_m();
		test_delegation();
		test_returns();
		test_timer();

		$display("%0d tests run, %0d failed, %0d errors", test_count, failed_tests, err_count);
		if (err_count == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
+incdir+rtl
+incdir+sim
rtl/priv_pkg.sv
rtl/csr_map_pkg.sv
rtl/priv_router.sv
rtl/priv_level_bank.sv
rtl/csr_read_path.sv
rtl/csr_top.sv
sim/tb_csr_top.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_csr_top
RTL_TOP    ?= csr_top
FILELIST   ?= compile.f
OBJ_DIR    ?= obj_dir
JOBS       ?= 4
LINT_FLAGS ?= --timing --assert
SIM_FLAGS  ?= --timing --assert -Wno-fatal
PASS_MSG   ?= Test OK

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(SIM_FLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
